// File: verilog/axi_rd_pkg.sv
package axi_rd_pkg;

	localparam int AXI_ID_BITS   = 4;
	localparam int AXI_IDS_BITS  = 8;
	localparam int AXI_DATA_BITS = 32;
	localparam int AXI_ADDR_BITS = 32;
	localparam int AXI_LEN_BITS  = 4;

	localparam logic [1:0] AXI_RESP_OKAY   = 2'd0;
	localparam logic [1:0] AXI_RESP_DECERR = 2'd3;

	localparam logic [1:0] AXI_BURST_FIXED = 2'd0;
	localparam logic [1:0] AXI_BURST_INC   = 2'd1;

	// Slave index, SLV_DEF is the built-in DECERR responder
	localparam logic [2:0] SLV_S0  = 3'd0;
	localparam logic [2:0] SLV_S1  = 3'd1;
	localparam logic [2:0] SLV_S2  = 3'd2;
	localparam logic [2:0] SLV_DEF = 3'd6;

	localparam logic [3:0] R_IDLE    = 4'd0;
	localparam logic [3:0] R_M0_ADDR = 4'd4;
	localparam logic [3:0] R_M1_ADDR = 4'd5;
	localparam logic [3:0] R_M0_DATA = 4'd7;
	localparam logic [3:0] R_M1_DATA = 4'd8;

	// Address map, upper half-word picks the region
	localparam int ADDR_REGION_HI = 31;
	localparam int ADDR_REGION_LO = 16;
	localparam logic [15:0] REGION_S0 = 16'h0000;
	localparam logic [15:0] REGION_S1 = 16'h0001;
	localparam logic [15:0] REGION_S2 = 16'h0002;

	// Slave-side ID, raw word or master tag plus master ID
	typedef union packed {
		logic [AXI_IDS_BITS-1:0] raw;
		struct packed {
			logic [AXI_IDS_BITS-AXI_ID_BITS-1:0] mst;
			logic [AXI_ID_BITS-1:0] id;
		} tag;
	} axi_ids_u;

endpackage

// File: verilog/ar_arbiter.sv
`timescale 1ns/1ps

module ar_arbiter (
	input  logic ACLK,
	input  logic ARESETn,
	input  logic arvalid_m0,
	input  logic arvalid_m1,
	input  logic [3:0] cs,
	output logic gnt_m0,
	output logic gnt_m1,
	output logic arready_m0,
	output logic arready_m1
);
	import axi_rd_pkg::*;

	logic idle;
	// High when M1 wins a tie
	logic prio_m1;

	assign idle = (cs == R_IDLE);

	always_comb begin
		gnt_m0 = 1'b0;
		gnt_m1 = 1'b0;
		if (idle) begin
			if (arvalid_m0 && arvalid_m1) begin
				gnt_m0 = !prio_m1;
				gnt_m1 = prio_m1;
			end else begin
				gnt_m0 = arvalid_m0;
				gnt_m1 = arvalid_m1;
			end
		end
	end

	// Grant doubles as AR accept for the winner
	assign arready_m0 = gnt_m0;
	assign arready_m1 = gnt_m1;

	// Last winner drops to low priority
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			prio_m1 <= 1'b0;
		end else if (gnt_m0 || gnt_m1) begin
			prio_m1 <= gnt_m0;
		end
	end

endmodule

// File: verilog/ar_decoder.sv
`timescale 1ns/1ps

module ar_decoder (
	input  logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr,
	input  logic ar_pend,
	input  logic [3:0] cs,
	input  logic arready_s0,
	input  logic arready_s1,
	input  logic arready_s2,
	output logic [2:0] slave_sel,
	output logic arvalid_s0,
	output logic arvalid_s1,
	output logic arvalid_s2,
	output logic ar_done
);
	import axi_rd_pkg::*;

	logic [ADDR_REGION_HI-ADDR_REGION_LO:0] region;
	logic addr_phase;

	assign region = araddr[ADDR_REGION_HI:ADDR_REGION_LO];

	// Only drive a slave while the FSM is really in an ADDR state
	assign addr_phase = ar_pend && ((cs == R_M0_ADDR) || (cs == R_M1_ADDR));

	always_comb begin
		case (region)
			REGION_S0: slave_sel = SLV_S0;
			REGION_S1: slave_sel = SLV_S1;
			REGION_S2: slave_sel = SLV_S2;
			default:   slave_sel = SLV_DEF;
		endcase
	end

	assign arvalid_s0 = addr_phase && (slave_sel == SLV_S0);
	assign arvalid_s1 = addr_phase && (slave_sel == SLV_S1);
	assign arvalid_s2 = addr_phase && (slave_sel == SLV_S2);

	// Default slave takes the address without a handshake
	assign ar_done = (arvalid_s0 && arready_s0)
		|| (arvalid_s1 && arready_s1)
		|| (arvalid_s2 && arready_s2)
		|| (addr_phase && (slave_sel == SLV_DEF));

endmodule

// File: verilog/rd_txn_ctrl.sv
`timescale 1ns/1ps

module rd_txn_ctrl (
	input  logic ACLK,
	input  logic ARESETn,
	input  logic gnt_m0,
	input  logic gnt_m1,
	input  logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr_m0,
	input  logic [axi_rd_pkg::AXI_ID_BITS-1:0] arid_m0,
	input  logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_m0,
	input  logic [1:0] arburst_m0,
	input  logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr_m1,
	input  logic [axi_rd_pkg::AXI_ID_BITS-1:0] arid_m1,
	input  logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_m1,
	input  logic [1:0] arburst_m1,
	input  logic [2:0] slave_sel,
	input  logic ar_done,
	input  logic r_done,
	output logic [3:0] cs,
	output logic [2:0] slave,
	output axi_rd_pkg::axi_ids_u arid_bus,
	output logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr_bus,
	output logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_bus,
	output logic [1:0] arburst_bus,
	output logic ar_pend
);
	import axi_rd_pkg::*;

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			cs <= R_IDLE;
			slave <= SLV_DEF;
		end else begin
			case (cs)
				R_IDLE: begin
					if (gnt_m0) begin
						cs <= R_M0_ADDR;
					end else if (gnt_m1) begin
						cs <= R_M1_ADDR;
					end
				end
				R_M0_ADDR: begin
					if (ar_done) begin
						cs <= R_M0_DATA;
					end
				end
				R_M1_ADDR: begin
					if (ar_done) begin
						cs <= R_M1_DATA;
					end
				end
				R_M0_DATA, R_M1_DATA: begin
					if (r_done) begin
						cs <= R_IDLE;
					end
				end
				default: cs <= R_IDLE;
			endcase
			// Route frozen for the whole data phase
			if (ar_done) begin
				slave <= slave_sel;
			end
		end
	end

	// Capture the winner's request, master number goes in the ID tag
	always_ff @(posedge ACLK) begin
		if (gnt_m0) begin
			arid_bus.tag.mst <= 4'd0;
			arid_bus.tag.id <= arid_m0;
			araddr_bus <= araddr_m0;
			arlen_bus <= arlen_m0;
			arburst_bus <= arburst_m0;
		end else if (gnt_m1) begin
			arid_bus.tag.mst <= 4'd1;
			arid_bus.tag.id <= arid_m1;
			araddr_bus <= araddr_m1;
			arlen_bus <= arlen_m1;
			arburst_bus <= arburst_m1;
		end
	end

	assign ar_pend = (cs == R_M0_ADDR) || (cs == R_M1_ADDR);

endmodule

// File: verilog/r_channel.sv
`timescale 1ns/1ps

module r_channel (
	input  logic ACLK,
	input  logic ARESETn,
	input  logic [axi_rd_pkg::AXI_IDS_BITS-1:0] rid_s0,
	input  logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_s0,
	input  logic [1:0] rresp_s0,
	input  logic rlast_s0,
	input  logic rvalid_s0,
	input  logic [axi_rd_pkg::AXI_IDS_BITS-1:0] rid_s1,
	input  logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_s1,
	input  logic [1:0] rresp_s1,
	input  logic rlast_s1,
	input  logic rvalid_s1,
	input  logic [axi_rd_pkg::AXI_IDS_BITS-1:0] rid_s2,
	input  logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_s2,
	input  logic [1:0] rresp_s2,
	input  logic rlast_s2,
	input  logic rvalid_s2,
	output logic rready_s0,
	output logic rready_s1,
	output logic rready_s2,
	input  logic rready_m0,
	input  logic rready_m1,
	output logic [axi_rd_pkg::AXI_ID_BITS-1:0] rid_m0,
	output logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_m0,
	output logic [1:0] rresp_m0,
	output logic rlast_m0,
	output logic rvalid_m0,
	output logic [axi_rd_pkg::AXI_ID_BITS-1:0] rid_m1,
	output logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_m1,
	output logic [1:0] rresp_m1,
	output logic rlast_m1,
	output logic rvalid_m1,
	input  logic [3:0] cs,
	input  logic [2:0] slave,
	input  axi_rd_pkg::axi_ids_u arid_bus,
	input  logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_bus,
	input  logic [1:0] arburst_bus,
	output logic r_done
);
	import axi_rd_pkg::*;

	axi_ids_u rid_bus;
	logic [AXI_DATA_BITS-1:0] rdata_bus;
	logic [1:0] rresp_bus;
	logic rlast_bus;
	logic rvalid_bus;
	logic rready_bus;
	logic beat;
	logic data_phase;
	logic [AXI_LEN_BITS-1:0] cnt;

	assign data_phase = (cs == R_M0_DATA) || (cs == R_M1_DATA);
	assign beat = rvalid_bus && rready_bus;
	assign r_done = beat && rlast_bus;

	// Beats accepted so far, used only by the default slave
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			cnt <= '0;
		end else if (!data_phase) begin
			cnt <= '0;
		end else if (beat) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Slave side, pick one R channel and steer ready back to it
	always_comb begin
		rready_s0 = 1'b0;
		rready_s1 = 1'b0;
		rready_s2 = 1'b0;
		case (slave)
			SLV_S0: begin
				rid_bus.raw = rid_s0;
				rdata_bus = rdata_s0;
				rresp_bus = rresp_s0;
				rlast_bus = rlast_s0;
				rvalid_bus = rvalid_s0;
				rready_s0 = rready_bus;
			end
			SLV_S1: begin
				rid_bus.raw = rid_s1;
				rdata_bus = rdata_s1;
				rresp_bus = rresp_s1;
				rlast_bus = rlast_s1;
				rvalid_bus = rvalid_s1;
				rready_s1 = rready_bus;
			end
			SLV_S2: begin
				rid_bus.raw = rid_s2;
				rdata_bus = rdata_s2;
				rresp_bus = rresp_s2;
				rlast_bus = rlast_s2;
				rvalid_bus = rvalid_s2;
				rready_s2 = rready_bus;
			end
			default: begin
				// DECERR responder, always has a beat ready
				rid_bus = arid_bus;
				rdata_bus = '0;
				rresp_bus = AXI_RESP_DECERR;
				if (arburst_bus == AXI_BURST_INC) begin
					rlast_bus = (cnt == arlen_bus);
				end else begin
					rlast_bus = 1'b1;
				end
				rvalid_bus = 1'b1;
			end
		endcase
	end

	// Master side, owner chosen by cs and the other one sees zeros
	always_comb begin
		rid_m0 = '0;
		rdata_m0 = '0;
		rresp_m0 = '0;
		rlast_m0 = 1'b0;
		rvalid_m0 = 1'b0;
		rid_m1 = '0;
		rdata_m1 = '0;
		rresp_m1 = '0;
		rlast_m1 = 1'b0;
		rvalid_m1 = 1'b0;
		rready_bus = 1'b0;
		if (cs == R_M0_DATA) begin
			rid_m0 = rid_bus.tag.id;
			rdata_m0 = rdata_bus;
			rresp_m0 = rresp_bus;
			rlast_m0 = rlast_bus;
			rvalid_m0 = rvalid_bus;
			rready_bus = rready_m0;
		end else if (cs == R_M1_DATA) begin
			rid_m1 = rid_bus.tag.id;
			rdata_m1 = rdata_bus;
			rresp_m1 = rresp_bus;
			rlast_m1 = rlast_bus;
			rvalid_m1 = rvalid_bus;
			rready_bus = rready_m1;
		end
	end

endmodule

// File: verilog/axi_rd_xbar.sv
`timescale 1ns/1ps

module axi_rd_xbar (
	input  logic ACLK,
	input  logic ARESETn,
	input  logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr_m0,
	input  logic [axi_rd_pkg::AXI_ID_BITS-1:0] arid_m0,
	input  logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_m0,
	input  logic [1:0] arburst_m0,
	input  logic arvalid_m0,
	output logic arready_m0,
	input  logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr_m1,
	input  logic [axi_rd_pkg::AXI_ID_BITS-1:0] arid_m1,
	input  logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_m1,
	input  logic [1:0] arburst_m1,
	input  logic arvalid_m1,
	output logic arready_m1,
	output logic [axi_rd_pkg::AXI_ID_BITS-1:0] rid_m0,
	output logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_m0,
	output logic [1:0] rresp_m0,
	output logic rlast_m0,
	output logic rvalid_m0,
	input  logic rready_m0,
	output logic [axi_rd_pkg::AXI_ID_BITS-1:0] rid_m1,
	output logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_m1,
	output logic [1:0] rresp_m1,
	output logic rlast_m1,
	output logic rvalid_m1,
	input  logic rready_m1,
	output logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr_s0,
	output logic [axi_rd_pkg::AXI_IDS_BITS-1:0] arid_s0,
	output logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_s0,
	output logic [1:0] arburst_s0,
	output logic arvalid_s0,
	input  logic arready_s0,
	output logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr_s1,
	output logic [axi_rd_pkg::AXI_IDS_BITS-1:0] arid_s1,
	output logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_s1,
	output logic [1:0] arburst_s1,
	output logic arvalid_s1,
	input  logic arready_s1,
	output logic [axi_rd_pkg::AXI_ADDR_BITS-1:0] araddr_s2,
	output logic [axi_rd_pkg::AXI_IDS_BITS-1:0] arid_s2,
	output logic [axi_rd_pkg::AXI_LEN_BITS-1:0] arlen_s2,
	output logic [1:0] arburst_s2,
	output logic arvalid_s2,
	input  logic arready_s2,
	input  logic [axi_rd_pkg::AXI_IDS_BITS-1:0] rid_s0,
	input  logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_s0,
	input  logic [1:0] rresp_s0,
	input  logic rlast_s0,
	input  logic rvalid_s0,
	output logic rready_s0,
	input  logic [axi_rd_pkg::AXI_IDS_BITS-1:0] rid_s1,
	input  logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_s1,
	input  logic [1:0] rresp_s1,
	input  logic rlast_s1,
	input  logic rvalid_s1,
	output logic rready_s1,
	input  logic [axi_rd_pkg::AXI_IDS_BITS-1:0] rid_s2,
	input  logic [axi_rd_pkg::AXI_DATA_BITS-1:0] rdata_s2,
	input  logic [1:0] rresp_s2,
	input  logic rlast_s2,
	input  logic rvalid_s2,
	output logic rready_s2
);
	import axi_rd_pkg::*;

	logic gnt_m0;
	logic gnt_m1;
	logic [3:0] cs;
	logic [2:0] slave;
	logic [2:0] slave_sel;
	axi_ids_u arid_bus;
	logic [AXI_ADDR_BITS-1:0] araddr_bus;
	logic [AXI_LEN_BITS-1:0] arlen_bus;
	logic [1:0] arburst_bus;
	logic ar_pend;
	logic ar_done;
	logic r_done;

	ar_arbiter arb_i (.*);

	ar_decoder dec_i (.araddr(araddr_bus), .*);

	rd_txn_ctrl ctrl_i (.*);

	r_channel rch_i (.*);

	// One latched request fans out to every slave, arvalid picks the target
	assign araddr_s0 = araddr_bus;
	assign arid_s0 = arid_bus.raw;
	assign arlen_s0 = arlen_bus;
	assign arburst_s0 = arburst_bus;
	assign araddr_s1 = araddr_bus;
	assign arid_s1 = arid_bus.raw;
	assign arlen_s1 = arlen_bus;
	assign arburst_s1 = arburst_bus;
	assign araddr_s2 = araddr_bus;
	assign arid_s2 = arid_bus.raw;
	assign arlen_s2 = arlen_bus;
	assign arburst_s2 = arburst_bus;

endmodule

// File: dv/axi_rd_xbar_asserts.sv
`timescale 1ns/1ps

module axi_rd_xbar_asserts (
	input logic ACLK,
	input logic ARESETn,
	input logic rvalid_m0,
	input logic rvalid_m1,
	input logic rready_m0,
	input logic rready_m1,
	input logic rready_s0,
	input logic rready_s1,
	input logic rready_s2,
	input logic [axi_rd_pkg::AXI_LEN_BITS-1:0] cnt
);

	// Only the burst owner may see a beat
	one_owner: assert property (@(posedge ACLK) disable iff (!ARESETn)
		!(rvalid_m0 && rvalid_m1))
		else $error("rvalid high on both masters at once");

	// A stalled beat stays offered
	hold_m0: assert property (@(posedge ACLK) disable iff (!ARESETn)
		rvalid_m0 && !rready_m0 |=> rvalid_m0)
		else $error("rvalid_m0 dropped before rready_m0");

	hold_m1: assert property (@(posedge ACLK) disable iff (!ARESETn)
		rvalid_m1 && !rready_m1 |=> rvalid_m1)
		else $error("rvalid_m1 dropped before rready_m1");

	ready_one_slave: assert property (@(posedge ACLK) disable iff (!ARESETn)
		$onehot0({rready_s0, rready_s1, rready_s2}))
		else $error("rready sent to more than one slave");

	quiet_after_reset: assert property (@(posedge ACLK)
		$rose(ARESETn) |-> (cnt == '0) && !rvalid_m0 && !rvalid_m1
			&& !rready_s0 && !rready_s1 && !rready_s2)
		else $error("R channel active right after reset");

endmodule

bind r_channel axi_rd_xbar_asserts asserts_i (.*);

// File: dv/tb_axi_rd_xbar.sv
`timescale 1ns/1ps

module tb_axi_rd_xbar;
	import axi_rd_pkg::*;

	localparam int NUM_TXN = 200;
	localparam int TIMEOUT_CYCLES = NUM_TXN * 40;

	typedef struct packed {
		logic mst;
		logic [3:0] id;
		logic [31:0] addr;
		logic [3:0] len;
		logic [1:0] burst;
		logic [2:0] slv;
	} txn_t;

	logic ACLK;
	logic ARESETn;

	// Master side, index is the master number
	logic [1:0][AXI_ADDR_BITS-1:0] araddr_m;
	logic [1:0][AXI_ID_BITS-1:0] arid_m;
	logic [1:0][AXI_LEN_BITS-1:0] arlen_m;
	logic [1:0][1:0] arburst_m;
	logic [1:0] arvalid_m;
	logic [1:0] rready_m;
	wire [1:0] arready_m;
	wire [1:0][AXI_ID_BITS-1:0] rid_m;
	wire [1:0][AXI_DATA_BITS-1:0] rdata_m;
	wire [1:0][1:0] rresp_m;
	wire [1:0] rlast_m;
	wire [1:0] rvalid_m;

	// Slave side, index is the slave number
	wire [2:0][AXI_ADDR_BITS-1:0] araddr_s;
	wire [2:0][AXI_IDS_BITS-1:0] arid_s;
	wire [2:0][AXI_LEN_BITS-1:0] arlen_s;
	wire [2:0][1:0] arburst_s;
	wire [2:0] arvalid_s;
	logic [2:0] arready_s;
	logic [2:0][AXI_IDS_BITS-1:0] rid_s;
	logic [2:0][AXI_DATA_BITS-1:0] rdata_s;
	logic [2:0][1:0] rresp_s;
	logic [2:0] rlast_s;
	logic [2:0] rvalid_s;
	wire [2:0] rready_s;

	// Reference model
	txn_t exp_q[$];
	txn_t cur;
	logic busy;
	logic ar_sent;
	logic prio;
	logic [1:0] m_taken;
	int rbeat;
	int issued;
	int done_cnt;
	int errors;
	int cycles;
	logic [31:0] lfsr;

	// Slave models
	logic [2:0] s_act;
	logic [2:0] s_rv;
	logic [2:0][3:0] s_idx;
	logic [2:0][3:0] s_len;
	logic [2:0][31:0] s_addr;
	logic [2:0][7:0] s_id;

	axi_rd_xbar dut_i (
		.ACLK(ACLK),
		.ARESETn(ARESETn),
		.araddr_m0(araddr_m[0]),
		.arid_m0(arid_m[0]),
		.arlen_m0(arlen_m[0]),
		.arburst_m0(arburst_m[0]),
		.arvalid_m0(arvalid_m[0]),
		.arready_m0(arready_m[0]),
		.araddr_m1(araddr_m[1]),
		.arid_m1(arid_m[1]),
		.arlen_m1(arlen_m[1]),
		.arburst_m1(arburst_m[1]),
		.arvalid_m1(arvalid_m[1]),
		.arready_m1(arready_m[1]),
		.rid_m0(rid_m[0]),
		.rdata_m0(rdata_m[0]),
		.rresp_m0(rresp_m[0]),
		.rlast_m0(rlast_m[0]),
		.rvalid_m0(rvalid_m[0]),
		.rready_m0(rready_m[0]),
		.rid_m1(rid_m[1]),
		.rdata_m1(rdata_m[1]),
		.rresp_m1(rresp_m[1]),
		.rlast_m1(rlast_m[1]),
		.rvalid_m1(rvalid_m[1]),
		.rready_m1(rready_m[1]),
		.araddr_s0(araddr_s[0]),
		.arid_s0(arid_s[0]),
		.arlen_s0(arlen_s[0]),
		.arburst_s0(arburst_s[0]),
		.arvalid_s0(arvalid_s[0]),
		.arready_s0(arready_s[0]),
		.araddr_s1(araddr_s[1]),
		.arid_s1(arid_s[1]),
		.arlen_s1(arlen_s[1]),
		.arburst_s1(arburst_s[1]),
		.arvalid_s1(arvalid_s[1]),
		.arready_s1(arready_s[1]),
		.araddr_s2(araddr_s[2]),
		.arid_s2(arid_s[2]),
		.arlen_s2(arlen_s[2]),
		.arburst_s2(arburst_s[2]),
		.arvalid_s2(arvalid_s[2]),
		.arready_s2(arready_s[2]),
		.rid_s0(rid_s[0]),
		.rdata_s0(rdata_s[0]),
		.rresp_s0(rresp_s[0]),
		.rlast_s0(rlast_s[0]),
		.rvalid_s0(rvalid_s[0]),
		.rready_s0(rready_s[0]),
		.rid_s1(rid_s[1]),
		.rdata_s1(rdata_s[1]),
		.rresp_s1(rresp_s[1]),
		.rlast_s1(rlast_s[1]),
		.rvalid_s1(rvalid_s[1]),
		.rready_s1(rready_s[1]),
		.rid_s2(rid_s[2]),
		.rdata_s2(rdata_s[2]),
		.rresp_s2(rresp_s[2]),
		.rlast_s2(rlast_s[2]),
		.rvalid_s2(rvalid_s[2]),
		.rready_s2(rready_s[2])
	);

	initial begin
		ACLK = 1'b0;
		forever begin
			#20 ACLK = ~ACLK;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [2:0] region_slave(input logic [31:0] addr);
		case (addr[31:16])
			16'h0000: return 3'd0;
			16'h0001: return 3'd1;
			16'h0002: return 3'd2;
			default:  return SLV_DEF;
		endcase
	endfunction

	// Default slave answers non-INCR bursts with a single beat
	function automatic int beats_of(input txn_t t);
		if (t.slv != SLV_DEF || t.burst == AXI_BURST_INC) begin
			return t.len + 1;
		end
		return 1;
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t ns: %s, got %h expected %h", $time, what, actual,
				expected);
			$display("Errors found");
			$fatal(1, "stopped at the first wrong value");
		end
	endtask

	task automatic new_request(input int m);
		logic [15:0] region;
		logic [15:0] low;
		logic [1:0] burst;
		region = rand_bits(2);
		// Region 3 stands for any unmapped region
		if (region == 16'd3) begin
			region = {rand_bits(14), 2'b11};
		end
		low = rand_bits(16);
		burst = rand_bits(2);
		if (burst == 2'd3) begin
			burst = AXI_BURST_INC;
		end
		araddr_m[m] = {region, low};
		arid_m[m] = rand_bits(4);
		arlen_m[m] = rand_bits(4);
		arburst_m[m] = burst;
		arvalid_m[m] = 1'b1;
	endtask

	// Runs 2 ns after the rising edge
	task automatic drive_cycle();
		int m;
		int s;
		for (m = 0; m < 2; m++) begin
			if (m_taken[m]) begin
				arvalid_m[m] = 1'b0;
				m_taken[m] = 1'b0;
			end
			if (!arvalid_m[m] && issued < NUM_TXN && rand_bits(1) == 1) begin
				new_request(m);
				issued++;
			end
			rready_m[m] = (rand_bits(2) != 0);
		end
		for (s = 0; s < 3; s++) begin
			arready_s[s] = (rand_bits(1) == 1);
			if (s_act[s] && !s_rv[s]) begin
				s_rv[s] = (rand_bits(2) != 0);
			end
			rvalid_s[s] = s_rv[s];
			rdata_s[s] = s_addr[s] + s_idx[s];
			rid_s[s] = s_id[s];
			rresp_s[s] = AXI_RESP_OKAY;
			rlast_s[s] = (s_idx[s] == s_len[s]);
		end
	endtask

	// Runs at the falling edge, handshakes seen here complete on the next rise
	task automatic sample_cycle();
		int m;
		int s;
		logic any_req;
		logic who;
		logic owner;
		logic last;
		txn_t t;
		for (s = 0; s < 3; s++) begin
			check_eq(arvalid_s[s], busy && !ar_sent && (cur.slv == s), "arvalid to slave");
			if (arvalid_s[s] && arready_s[s]) begin
				check_eq(araddr_s[s], cur.addr, "slave araddr");
				check_eq(arid_s[s], {3'd0, cur.mst, cur.id}, "slave arid");
				check_eq(arlen_s[s], cur.len, "slave arlen");
				check_eq(arburst_s[s], cur.burst, "slave arburst");
				s_act[s] = 1'b1;
				s_idx[s] = '0;
				s_len[s] = arlen_s[s];
				s_addr[s] = araddr_s[s];
				s_id[s] = arid_s[s];
				ar_sent = 1'b1;
			end
		end

		// Round robin, prio set means M1 wins a tie
		any_req = arvalid_m[0] || arvalid_m[1];
		who = (arvalid_m == 2'b11) ? prio : arvalid_m[1];
		check_eq(arready_m[0], !busy && any_req && !who, "arready_m0");
		check_eq(arready_m[1], !busy && any_req && who, "arready_m1");
		if (!busy && any_req) begin
			t.mst = who;
			t.id = arid_m[who];
			t.addr = araddr_m[who];
			t.len = arlen_m[who];
			t.burst = arburst_m[who];
			t.slv = region_slave(araddr_m[who]);
			exp_q.push_back(t);
			cur = t;
			busy = 1'b1;
			ar_sent = 1'b0;
			rbeat = 0;
			prio = !who;
			m_taken[who] = 1'b1;
		end

		// R beats are checked against the oldest recorded request
		for (m = 0; m < 2; m++) begin
			owner = (exp_q.size() != 0) && (exp_q[0].mst == m);
			if (!owner) begin
				check_eq(rvalid_m[m], 1'b0, "rvalid at a master with no open burst");
			end else if (rvalid_m[m] && rready_m[m]) begin
				t = exp_q[0];
				last = (rbeat == beats_of(t) - 1);
				check_eq(rid_m[m], t.id, "rid");
				if (t.slv == SLV_DEF) begin
					check_eq(rdata_m[m], 32'd0, "rdata from default slave");
					check_eq(rresp_m[m], AXI_RESP_DECERR, "rresp from default slave");
				end else begin
					check_eq(rdata_m[m], t.addr + rbeat, "rdata");
					check_eq(rresp_m[m], AXI_RESP_OKAY, "rresp");
				end
				check_eq(rlast_m[m], last, "rlast");
				if (last) begin
					void'(exp_q.pop_front());
					busy = 1'b0;
					rbeat = 0;
					done_cnt++;
				end else begin
					rbeat++;
				end
			end
		end

		for (s = 0; s < 3; s++) begin
			check_eq(rready_s[s] && !s_act[s], 1'b0, "rready to a slave with no open burst");
			if (rvalid_s[s] && rready_s[s]) begin
				if (s_idx[s] == s_len[s]) begin
					s_act[s] = 1'b0;
				end
				s_idx[s] = s_idx[s] + 1'b1;
				s_rv[s] = 1'b0;
			end
		end
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge ACLK);
			cycles++;
		end
		$display("timeout, %0d of %0d transactions finished in %0d cycles", done_cnt,
			NUM_TXN, cycles);
		$display("Errors found");
		$fatal(1, "run stopped by the cycle limit");
	end

	initial begin
		lfsr = 32'ha5d84096;
		ARESETn = 1'b0;
		araddr_m = '0;
		arid_m = '0;
		arlen_m = '0;
		arburst_m = '0;
		arvalid_m = '0;
		rready_m = '0;
		arready_s = '0;
		rid_s = '0;
		rdata_s = '0;
		rresp_s = '0;
		rlast_s = '0;
		rvalid_s = '0;
		cur = '0;
		busy = 1'b0;
		ar_sent = 1'b0;
		prio = 1'b0;
		m_taken = '0;
		rbeat = 0;
		issued = 0;
		done_cnt = 0;
		errors = 0;
		s_act = '0;
		s_rv = '0;
		s_idx = '0;
		s_len = '0;
		s_addr = '0;
		s_id = '0;
		repeat (2) @(posedge ACLK);
		#2;
		ARESETn = 1'b1;

		// Quiet window before the first request
		repeat (4) begin
			@(negedge ACLK);
			check_eq(arready_m, 2'b00, "arready after reset");
			check_eq(rvalid_m, 2'b00, "rvalid after reset");
		end

		while (done_cnt < NUM_TXN) begin
			@(posedge ACLK);
			#2;
			drive_cycle();
			@(negedge ACLK);
			sample_cycle();
		end

		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: src.f
verilog/axi_rd_pkg.sv
verilog/ar_arbiter.sv
verilog/ar_decoder.sv
verilog/rd_txn_ctrl.sv
verilog/r_channel.sv
verilog/axi_rd_xbar.sv
dv/axi_rd_xbar_asserts.sv
dv/tb_axi_rd_xbar.sv
